/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = adc_acq_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation passed" $(LOG) || (echo "test target: no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/adc_acq_checker.sv */
`default_nettype none

module adc_acq_checker (
    input  wire        clk,
    input  wire        adc_acq_full_reset,
    input  wire        acq_enable0,         // fill type bit 0
    input  wire        acq_enable1,         // fill type bit 1
    input  wire        mem_wr_en,
    input  wire [31:0] mem_addr,
    input  wire [31:0] mem_wr_data,
    input  wire        acq_done,
    input  wire        sm_idle,
    input  wire        end_check,           // run the closing checks this cycle
    input  wire [31:0] fills_expected,
    output int         value_errors,
    output int         addr_errors,
    output int         other_errors
);

    logic [1:0]  cur_type;
    logic [13:0] fill_num;                  // wraps like the header field
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    int          word_idx;                  // position inside the current fill
    int          fill_count;
    int          disabled_cycles;           // both enables low
    logic        done_armed;                // checksum seen, acq_done may rise
    logic        reset_q, acq_done_q, sm_idle_q;

    // fill size table
    function automatic int bursts_for_type(input logic [1:0] ftype);
        case (ftype)
            2'd1:    return 4;
            2'd2:    return 8;
            2'd3:    return 16;
            default: return 0;
        endcase
    endfunction

    // word idx of a fill: header, then burst words 0..n-1, then checksum
    function automatic logic [31:0] expected_word(input logic [1:0] ftype,
                                                  input logic [13:0] fnum, input int idx);
        int          n;
        int          k;
        logic [31:0] header;
        logic [31:0] sum;
        n      = bursts_for_type(ftype);
        header = {ftype, fnum, 16'(n)};
        if (idx == 0) return header;
        if (idx <= n) return 32'(idx - 1);
        sum = header;
        for (k = 0; k < n; k++) sum = sum + 32'(k);   // mod 2^32
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (adc_acq_full_reset) begin
            cur_type        = 2'd0;
            fill_num        = '0;
            exp_addr        = '0;
            word_idx        = 0;
            fill_count      = 0;
            disabled_cycles = 0;
            done_armed      = 1'b0;
            value_errors    = 0;
            addr_errors     = 0;
            other_errors    = 0;
        end else begin
            if (reset_q) begin                                  // first cycle out of reset
                check_value("sm_idle", 32'd1, 32'(sm_idle));
                check_value("acq_done", 32'd0, 32'(acq_done));
                check_value("mem_wr_en", 32'd0, 32'(mem_wr_en));
            end
            if (mem_wr_en) begin
                if (word_idx == 0) cur_type = {acq_enable1, acq_enable0};
                exp_data = expected_word(cur_type, fill_num, word_idx);
                check_value("mem_wr_data", exp_data, mem_wr_data);
                if (mem_addr !== exp_addr) begin
                    $display("[ERROR] %0t mem_addr expected %h actual %h",
                             $time, exp_addr, mem_addr);
                    addr_errors++;
                end
                exp_addr = exp_addr + 32'd1;                    // no gaps across fills
                if (word_idx == bursts_for_type(cur_type) + 1) begin
                    word_idx   = 0;
                    fill_num   = fill_num + 14'd1;
                    fill_count++;
                    done_armed = 1'b1;
                end else begin
                    word_idx++;
                end
            end
            if (acq_done && !acq_done_q) begin
                if (!done_armed) begin
                    $display("acq_done rose at %0t before the checksum of the fill", $time);
                    other_errors++;
                end
                done_armed = 1'b0;
            end
            if (acq_enable0 || acq_enable1) disabled_cycles = 0;
            else                            disabled_cycles++;
            if (disabled_cycles > 4 && sm_idle_q && !sm_idle) begin
                $display("sequencer left idle at %0t with acquisition disabled", $time);
                other_errors++;
            end
            if (end_check) begin
                if (word_idx != 0) begin
                    $display("fill %0d stopped after %0d of its words", fill_count, word_idx);
                    other_errors++;
                end
                if (fill_count != fills_expected) begin
                    $display("%0d fills written to memory but %0d expected",
                             fill_count, fills_expected);
                    other_errors++;
                end
            end
        end
        reset_q    = adc_acq_full_reset;
        acq_done_q = acq_done;
        sm_idle_q  = sm_idle;
    end

endmodule

`default_nettype wire

/* sim/adc_acq_tb.sv */
`default_nettype none

module adc_acq_tb;

    localparam int          FIFO_DEPTH     = 32;
    localparam int          RESET_CYCLES   = 16;
    localparam int          PLANNED_FILLS  = 7;    // 3 types, 2 with back-pressure, 2 on one trigger pair
    localparam int          TIMEOUT_CYCLES = PLANNED_FILLS * 200 + RESET_CYCLES;
    localparam int unsigned SEED           = 32'h4dab_9c0b;

    logic        clk;
    logic        adc_acq_full_reset;
    logic        acq_enable0, acq_enable1;   // fill type, both low is readout mode
    logic        acq_trig;
    logic        mem_ready;
    logic        mem_wr_en, acq_done, sm_idle;
    logic [31:0] mem_addr, mem_wr_data;
    logic        end_check;                  // closing checks in the checker
    int          fills_expected;
    int          value_errors, addr_errors, other_errors;

    adc_acq_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_adc_acq_top (.clk, .adc_acq_full_reset,
        .acq_enable0, .acq_enable1, .acq_trig, .mem_ready, .mem_wr_en, .mem_addr,
        .mem_wr_data, .acq_done, .sm_idle);

    adc_acq_checker u_adc_acq_checker (.clk, .adc_acq_full_reset, .acq_enable0, .acq_enable1,
        .mem_wr_en, .mem_addr, .mem_wr_data, .acq_done, .sm_idle, .end_check, .fills_expected,
        .value_errors, .addr_errors, .other_errors);

    always #2 clk = ~clk;   // period 4

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one fill of type ftype, trigger held for hold_cycles after acq_done
    task automatic run_fill(input logic [1:0] ftype, input bit random_ready, input int hold_cycles);
        @(negedge clk);
        acq_enable0 = ftype[0];
        acq_enable1 = ftype[1];
        wait_cycles(4);                      // enables through the synchronizers
        acq_trig = 1'b1;
        fills_expected++;
        while (!acq_done) begin
            @(negedge clk);
            if (random_ready) mem_ready = ($urandom % 2) == 1;   // memory stalls at random
        end
        mem_ready = 1'b1;
        wait_cycles(hold_cycles);            // sequencer sits in DONE meanwhile
        acq_trig = 1'b0;
        while (!sm_idle) @(negedge clk);
        wait_cycles(3);
    endtask

    initial begin
        clk                = 1'b0;
        adc_acq_full_reset = 1'b1;
        acq_enable0        = 1'b0;
        acq_enable1        = 1'b0;
        acq_trig           = 1'b0;
        mem_ready          = 1'b1;
        end_check          = 1'b0;
        fills_expected     = 0;
        void'($urandom(SEED));
        wait_cycles(RESET_CYCLES);
        adc_acq_full_reset = 1'b0;
        wait_cycles(4);
        run_fill(2'd1, 1'b0, 0);             // each type at full memory speed
        run_fill(2'd2, 1'b0, 0);
        run_fill(2'd3, 1'b0, 0);
        run_fill(2'd3, 1'b1, 0);             // back-pressure from the memory
        run_fill(2'd1, 1'b1, 0);
        run_fill(2'd2, 1'b0, 60);            // long trigger, still one fill
        run_fill(2'd2, 1'b0, 0);             // retrigger, next fill number
        @(negedge clk);
        acq_enable0 = 1'b0;                  // readout mode, trigger ignored
        acq_enable1 = 1'b0;
        wait_cycles(8);
        acq_trig = 1'b1;
        wait_cycles(40);
        acq_trig = 1'b0;
        wait_cycles(8);
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        wait_cycles(2);
        $display("errors: value %0d, address %0d, other %0d",
                 value_errors, addr_errors, other_errors);
        if (value_errors + addr_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: value %0d, address %0d, other %0d",
                 value_errors, addr_errors, other_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* source/adc_acq_fifo.sv */
`default_nettype none

module adc_acq_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  wire                                clk,
    input  wire                                adc_acq_full_reset,
    input  wire                                wr_en,
    input  wire  [adc_acq_pkg::DATA_WIDTH-1:0] wr_data,
    input  wire                                rd_en,
    output logic [adc_acq_pkg::DATA_WIDTH-1:0] rd_data,   // head word, fall through
    output logic                               empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [adc_acq_pkg::DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;        // words held
    logic             full;
    logic             do_wr, do_rd;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_data;
    end

    // pointers wrap at depth, so non power of two depths work
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)      count <= count + 1'b1;
            else if (!do_wr && do_rd) count <= count - 1'b1;
        end
    end

    assign rd_data = mem[rd_ptr];

    a_no_write_full: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        !(wr_en && full)) else $error("fifo write while full");
    a_no_read_empty: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        !(rd_en && empty)) else $error("fifo read while empty");

endmodule

`default_nettype wire

/* source/adc_acq_pkg.sv */
`default_nettype none

package adc_acq_pkg;

    // word width of the fifo and of the memory bus, fixed by the header layout
    localparam int DATA_WIDTH      = 32;
    localparam int FILL_TYPE_WIDTH = 2;    // header bits 31:30
    localparam int FILL_NUM_WIDTH  = 14;   // header bits 29:16
    localparam int BURST_CNT_WIDTH = 16;   // header bits 15:0

    // bursts per fill, indexed by fill type
    localparam logic [BURST_CNT_WIDTH-1:0] FILL_BURSTS_1 = 16'd4;
    localparam logic [BURST_CNT_WIDTH-1:0] FILL_BURSTS_2 = 16'd8;
    localparam logic [BURST_CNT_WIDTH-1:0] FILL_BURSTS_3 = 16'd16;

    // fill sequencer states
    typedef enum logic [3:0] {
        IDLE      = 4'd0,    // waiting for enable and trigger
        INIT1     = 4'd1,    // latch fill size
        INIT2     = 4'd2,    // load burst counter, header on the mux
        INIT3     = 4'd3,    // header word to fifo
        RUN1      = 4'd4,    // burst counter decrement
        RUN2      = 4'd5,
        RUN3      = 4'd6,
        RUN4      = 4'd7,    // burst word to fifo
        CHECKSUM1 = 4'd8,    // checksum on the mux
        CHECKSUM2 = 4'd9,    // checksum word to fifo
        DDR3_WAIT = 4'd10,   // wait for the memory side to store the fill
        DONE      = 4'd11    // hold until trigger released
    } acq_state_t;

    // memory write controller position inside a fill
    typedef enum logic [1:0] {
        WR_HEADER   = 2'd0,
        WR_DATA     = 2'd1,
        WR_CHECKSUM = 2'd2
    } wr_state_t;

endpackage

`default_nettype wire

/* source/adc_acq_sm.sv */
`default_nettype none

module adc_acq_sm (
    input  wire        clk,
    input  wire        adc_acq_full_reset,
    input  wire        acq_enable0,              // enable and fill type, bit 0
    input  wire        acq_enable1,              // enable and fill type, bit 1
    input  wire        acq_trig,                 // async trigger
    input  wire        burst_cntr_zero,          // last burst reached
    input  wire        ddr3_wr_done,             // fill stored in memory
    output logic [1:0] fill_type,
    output logic       fill_size_mux_en,
    output logic       dummy_dat_reset,
    output logic       adc_mux_dat_sel,          // 0 header, 1 sample
    output logic       adc_mux_checksum_select,  // 1 checksum
    output logic       burst_cntr_init,
    output logic       burst_cntr_en,
    output logic       fill_cntr_en,
    output logic       adc_acq_out_valid,        // fifo write strobe
    output logic       acq_done,
    output logic       sm_idle
);

    logic enable0_sync1, enable0_sync2;
    logic enable1_sync1, enable1_sync2;
    logic trig_sync1, trig_sync2;
    logic acq_mode_enabled;                      // either enable set

    adc_acq_pkg::acq_state_t cs, ns;

    // two flop synchronizers on the async inputs
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            enable0_sync1 <= 1'b0;
            enable0_sync2 <= 1'b0;
            enable1_sync1 <= 1'b0;
            enable1_sync2 <= 1'b0;
            trig_sync1    <= 1'b0;
            trig_sync2    <= 1'b0;
        end else begin
            enable0_sync1 <= acq_enable0;
            enable0_sync2 <= enable0_sync1;
            enable1_sync1 <= acq_enable1;
            enable1_sync2 <= enable1_sync1;
            trig_sync1    <= acq_trig;
            trig_sync2    <= trig_sync1;
        end
    end

    // both enables low means readout mode, triggers ignored
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            acq_mode_enabled <= 1'b0;
            fill_type        <= 2'd0;
        end else begin
            acq_mode_enabled <= enable0_sync2 | enable1_sync2;
            fill_type        <= {enable1_sync2, enable0_sync2};
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) cs <= adc_acq_pkg::IDLE;
        else                    cs <= ns;
    end

    always_comb begin
        ns = cs;                                 // hold by default
        unique case (cs)
            adc_acq_pkg::IDLE:      if (acq_mode_enabled && trig_sync2) ns = adc_acq_pkg::INIT1;
            adc_acq_pkg::INIT1:     ns = adc_acq_pkg::INIT2;
            adc_acq_pkg::INIT2:     ns = adc_acq_pkg::INIT3;
            adc_acq_pkg::INIT3:     ns = adc_acq_pkg::RUN1;
            adc_acq_pkg::RUN1:      ns = adc_acq_pkg::RUN2;
            adc_acq_pkg::RUN2:      ns = adc_acq_pkg::RUN3;
            adc_acq_pkg::RUN3:      ns = adc_acq_pkg::RUN4;
            adc_acq_pkg::RUN4:      ns = burst_cntr_zero ? adc_acq_pkg::CHECKSUM1
                                                         : adc_acq_pkg::RUN1;
            adc_acq_pkg::CHECKSUM1: ns = adc_acq_pkg::CHECKSUM2;
            adc_acq_pkg::CHECKSUM2: ns = adc_acq_pkg::DDR3_WAIT;
            adc_acq_pkg::DDR3_WAIT: if (ddr3_wr_done) ns = adc_acq_pkg::DONE;
            adc_acq_pkg::DONE:      if (!(acq_mode_enabled && trig_sync2)) ns = adc_acq_pkg::IDLE;
            default:                ns = adc_acq_pkg::IDLE;
        endcase
    end

    // outputs registered from ns so they line up with cs
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            fill_size_mux_en        <= 1'b0;
            dummy_dat_reset         <= 1'b0;
            adc_mux_dat_sel         <= 1'b1;
            adc_mux_checksum_select <= 1'b0;
            burst_cntr_init         <= 1'b0;
            burst_cntr_en           <= 1'b0;
            fill_cntr_en            <= 1'b0;
            adc_acq_out_valid       <= 1'b0;
            acq_done                <= 1'b0;
            sm_idle                 <= 1'b1;
        end else begin
            fill_size_mux_en        <= (ns == adc_acq_pkg::INIT1);
            dummy_dat_reset         <= (ns == adc_acq_pkg::IDLE);   // clear sample and sum
            adc_mux_dat_sel         <= !(ns inside {adc_acq_pkg::INIT2, adc_acq_pkg::INIT3});
            adc_mux_checksum_select <= (ns inside {adc_acq_pkg::CHECKSUM1,
                                                   adc_acq_pkg::CHECKSUM2});
            burst_cntr_init         <= (ns == adc_acq_pkg::INIT2);
            burst_cntr_en           <= (ns == adc_acq_pkg::RUN1);
            fill_cntr_en            <= (ns == adc_acq_pkg::CHECKSUM2);  // next fill number
            adc_acq_out_valid       <= (ns inside {adc_acq_pkg::INIT3, adc_acq_pkg::RUN4,
                                                   adc_acq_pkg::CHECKSUM2});
            acq_done                <= (ns == adc_acq_pkg::DONE);
            sm_idle                 <= (ns == adc_acq_pkg::IDLE);
        end
    end

    // registered strobe must agree with the registered state
    a_valid_in_write_state: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset)
        adc_acq_out_valid |-> (cs inside {adc_acq_pkg::INIT3, adc_acq_pkg::RUN4,
                                          adc_acq_pkg::CHECKSUM2})
    ) else $error("adc_acq_out_valid outside a write state");

endmodule

`default_nettype wire

/* source/adc_acq_top.sv */
`default_nettype none

module adc_acq_top #(
    parameter int FIFO_DEPTH = 32       // at least 18, the largest fill
) (
    input  wire         clk,
    input  wire         adc_acq_full_reset,
    input  wire         acq_enable0,
    input  wire         acq_enable1,
    input  wire         acq_trig,
    input  wire         mem_ready,
    output logic        mem_wr_en,
    output logic [31:0] mem_addr,
    output logic [adc_acq_pkg::DATA_WIDTH-1:0] mem_wr_data,
    output logic        acq_done,
    output logic        sm_idle
);

    logic [1:0] fill_type;
    logic       fill_size_mux_en, dummy_dat_reset;
    logic       adc_mux_dat_sel, adc_mux_checksum_select;
    logic       burst_cntr_init, burst_cntr_en, burst_cntr_zero;
    logic       fill_cntr_en;
    logic       adc_acq_out_valid;                       // producer to fifo strobe
    logic       ddr3_wr_done;
    logic       fifo_empty, fifo_rd_en;
    logic [adc_acq_pkg::DATA_WIDTH-1:0] wr_data, rd_data;

    adc_acq_sm u_adc_acq_sm (.clk, .adc_acq_full_reset, .acq_enable0, .acq_enable1, .acq_trig,
        .burst_cntr_zero, .ddr3_wr_done, .fill_type, .fill_size_mux_en, .dummy_dat_reset,
        .adc_mux_dat_sel, .adc_mux_checksum_select, .burst_cntr_init, .burst_cntr_en,
        .fill_cntr_en, .adc_acq_out_valid, .acq_done, .sm_idle);

    adc_burst_datapath u_adc_burst_datapath (.clk, .adc_acq_full_reset, .fill_type,
        .fill_size_mux_en, .dummy_dat_reset, .adc_mux_dat_sel, .adc_mux_checksum_select,
        .burst_cntr_init, .burst_cntr_en, .fill_cntr_en, .adc_acq_out_valid,
        .burst_cntr_zero, .wr_data);

    adc_acq_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_adc_acq_fifo (.clk, .adc_acq_full_reset,
        .wr_en(adc_acq_out_valid), .wr_data, .rd_en(fifo_rd_en), .rd_data,
        .empty(fifo_empty));

    ddr3_wr_control u_ddr3_wr_control (.clk, .adc_acq_full_reset, .fifo_empty,
        .fifo_rd_data(rd_data), .mem_ready, .fifo_rd_en, .mem_wr_en, .mem_addr,
        .mem_wr_data, .ddr3_wr_done);

endmodule

`default_nettype wire

/* source/adc_burst_datapath.sv */
`default_nettype none

module adc_burst_datapath (
    input  wire        clk,
    input  wire        adc_acq_full_reset,
    input  wire  [1:0] fill_type,
    input  wire        fill_size_mux_en,          // latch fill size and type
    input  wire        dummy_dat_reset,           // clear sample counter and checksum
    input  wire        adc_mux_dat_sel,
    input  wire        adc_mux_checksum_select,
    input  wire        burst_cntr_init,
    input  wire        burst_cntr_en,
    input  wire        fill_cntr_en,
    input  wire        adc_acq_out_valid,         // word written to fifo this cycle
    output logic       burst_cntr_zero,
    output logic [adc_acq_pkg::DATA_WIDTH-1:0] wr_data
);

    logic [adc_acq_pkg::BURST_CNT_WIDTH-1:0] fill_size_sel;   // table lookup
    logic [adc_acq_pkg::BURST_CNT_WIDTH-1:0] fill_size;       // latched at INIT1
    logic [adc_acq_pkg::FILL_TYPE_WIDTH-1:0] fill_type_q;     // type for the header
    logic [adc_acq_pkg::BURST_CNT_WIDTH-1:0] burst_cntr;
    logic [adc_acq_pkg::FILL_NUM_WIDTH-1:0]  fill_num;
    logic [adc_acq_pkg::DATA_WIDTH-1:0]      sample_cnt;      // dummy adc data
    logic [adc_acq_pkg::DATA_WIDTH-1:0]      checksum;
    logic [adc_acq_pkg::DATA_WIDTH-1:0]      header;

    // fill size table
    always_comb begin
        unique case (fill_type)
            2'd1:    fill_size_sel = adc_acq_pkg::FILL_BURSTS_1;
            2'd2:    fill_size_sel = adc_acq_pkg::FILL_BURSTS_2;
            2'd3:    fill_size_sel = adc_acq_pkg::FILL_BURSTS_3;
            default: fill_size_sel = '0;   // readout mode, never armed
        endcase
    end

    always_ff @(posedge clk) begin
        if (fill_size_mux_en) begin
            fill_size   <= fill_size_sel;
            fill_type_q <= fill_type;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cntr <= '0;
            fill_num   <= '0;
        end else begin
            if (burst_cntr_init)    burst_cntr <= fill_size;
            else if (burst_cntr_en) burst_cntr <= burst_cntr - 1'b1;   // one per burst
            if (fill_cntr_en)       fill_num   <= fill_num + 1'b1;     // wraps at 14 bits
        end
    end

    assign burst_cntr_zero = (burst_cntr == '0);

    // sample counter steps on each burst word, checksum sums header and bursts
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset || dummy_dat_reset) begin
            sample_cnt <= '0;
            checksum   <= '0;
        end else if (adc_acq_out_valid && !adc_mux_checksum_select) begin
            checksum <= checksum + wr_data;
            if (adc_mux_dat_sel) sample_cnt <= sample_cnt + 1'b1;
        end
    end

    assign header = {fill_type_q, fill_num, fill_size};   // type, number, burst count

    // checksum select wins over the header/sample select
    always_comb begin
        if (adc_mux_checksum_select) wr_data = checksum;
        else if (!adc_mux_dat_sel)   wr_data = header;
        else                         wr_data = sample_cnt;
    end

endmodule

`default_nettype wire

/* source/ddr3_wr_control.sv */
`default_nettype none

module ddr3_wr_control (
    input  wire                                clk,
    input  wire                                adc_acq_full_reset,
    input  wire                                fifo_empty,
    input  wire  [adc_acq_pkg::DATA_WIDTH-1:0] fifo_rd_data,
    input  wire                                mem_ready,      // memory can take a write
    output logic                               fifo_rd_en,
    output logic                               mem_wr_en,
    output logic [31:0]                        mem_addr,
    output logic [adc_acq_pkg::DATA_WIDTH-1:0] mem_wr_data,
    output logic                               ddr3_wr_done    // pulse after checksum write
);

    adc_acq_pkg::wr_state_t wr_state;
    logic [adc_acq_pkg::BURST_CNT_WIDTH-1:0] bursts_left;    // burst words still to write

    // pop and write in the same cycle
    assign fifo_rd_en  = !fifo_empty && mem_ready;
    assign mem_wr_en   = fifo_rd_en;
    assign mem_wr_data = fifo_rd_data;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_state     <= adc_acq_pkg::WR_HEADER;
            bursts_left  <= '0;
            mem_addr     <= '0;
            ddr3_wr_done <= 1'b0;
        end else begin
            ddr3_wr_done <= mem_wr_en && (wr_state == adc_acq_pkg::WR_CHECKSUM);
            if (mem_wr_en) begin
                mem_addr <= mem_addr + 1'b1;   // sequential, continues across fills
                unique case (wr_state)
                    adc_acq_pkg::WR_HEADER: begin
                        // burst count sits in the low header field
                        bursts_left <= fifo_rd_data[adc_acq_pkg::BURST_CNT_WIDTH-1:0];
                        if (fifo_rd_data[adc_acq_pkg::BURST_CNT_WIDTH-1:0] == '0)
                            wr_state <= adc_acq_pkg::WR_CHECKSUM;
                        else
                            wr_state <= adc_acq_pkg::WR_DATA;
                    end
                    adc_acq_pkg::WR_DATA: begin
                        bursts_left <= bursts_left - 1'b1;
                        if (bursts_left == 1) wr_state <= adc_acq_pkg::WR_CHECKSUM;  // last burst
                    end
                    adc_acq_pkg::WR_CHECKSUM: wr_state <= adc_acq_pkg::WR_HEADER;
                    default:                  wr_state <= adc_acq_pkg::WR_HEADER;
                endcase
            end
        end
    end

    // one fill per done, and a fill is at least two words
    a_done_single_pulse: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        ddr3_wr_done |=> !ddr3_wr_done) else $error("ddr3_wr_done high two cycles");

endmodule

`default_nettype wire

/* vlog.f */
source/adc_acq_pkg.sv
source/adc_acq_sm.sv
source/adc_burst_datapath.sv
source/adc_acq_fifo.sv
source/ddr3_wr_control.sv
source/adc_acq_top.sv
sim/adc_acq_checker.sv
sim/adc_acq_tb.sv
